//--- mips_core.f
source/mips_isa_pkg.sv
source/mips_pipe_pkg.sv
source/mips_decode.sv
source/mips_regfile.sv
source/mips_hazard.sv
source/mips_execute.sv
source/mips_core.sv
bench/mips_core_properties.sv
bench/mips_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the core and its testbench with Verilator, run it and look for the pass message
# the error limit lets failed assertions reach the testbench summary
verilator --binary --assert --top-module mips_core_tb -f mips_core.f -o mips_core_sim \
   && ./obj_dir/mips_core_sim +verilator+error+limit+100 | tee /dev/stderr \
   | grep "All tests passed" > /dev/null \
   && echo "simulation run ok" \
   || { echo "simulation run failed"; exit 1; }

//--- bench/mips_core_tb.sv
// testbench with clock, reset, memory models, encoders, directed tests, compare tasks, watchdog
`timescale 1ns/1ps

module mips_core_tb;

   localparam int clk_period = 10;
   localparam int mem_words = 256;
   localparam int test_count = 5;
   localparam int cycles_per_test = 200;
   localparam int run_limit = 150;

   logic                     clk;
   logic                     rst_b;
   mips_isa_pkg::word_addr_t inst_addr;
   mips_isa_pkg::word_t      inst;
   mips_isa_pkg::word_addr_t mem_addr;
   mips_isa_pkg::word_t      mem_data_in;
   logic [3:0]               mem_write_en;
   mips_isa_pkg::word_t      mem_data_out;
   logic                     halted;

   mips_isa_pkg::word_t imem [mem_words];
   mips_isa_pkg::word_t dmem [mem_words];
   int prog_len;
   int errors;

   mips_core UUT (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .mem_data_out (mem_data_out),
      .halted       (halted)
   );

   bind mips_core mips_core_properties u_properties (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .mem_write_en (mem_write_en),
      .halted       (halted),
      .stall        (stall),
      .flush        (flush)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // untouched data words read back as this, so stray stores show up
   function automatic mips_isa_pkg::word_t fill_value(input int idx);
      return 32'h5a5a_0000 ^ mips_isa_pkg::word_t'(idx);
   endfunction

   // both memories answer in the same cycle
   // text_start maps to word 0
   assign inst = imem[inst_addr[7:0]];
   assign mem_data_out = rst_b ? dmem[mem_addr[7:0]] : '0;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < mem_words; i++)
            dmem[i] <= fill_value(i);
      end else if (mem_write_en == 4'hf) begin
         dmem[mem_addr[7:0]] <= mem_data_in;
      end
   end

   function automatic mips_isa_pkg::word_t r_type(input mips_isa_pkg::funct_t fn,
      input mips_isa_pkg::reg_addr_t rd, input mips_isa_pkg::reg_addr_t rs,
      input mips_isa_pkg::reg_addr_t rt);
      return {mips_isa_pkg::op_special, rs, rt, rd, 5'b00000, fn};
   endfunction

   // operand order follows assembly (op rt rs imm)
   function automatic mips_isa_pkg::word_t i_type(input mips_isa_pkg::opcode_t op,
      input mips_isa_pkg::reg_addr_t rt, input mips_isa_pkg::reg_addr_t rs,
      input mips_isa_pkg::imm16_t imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic mips_isa_pkg::word_t jump_to(input int idx);
      mips_isa_pkg::word_t target;
      target = mips_isa_pkg::text_start + mips_isa_pkg::word_t'(4 * idx);
      return {mips_isa_pkg::op_j, target[27:2]};
   endfunction

   // sw to data word idx with base $zero
   function automatic mips_isa_pkg::word_t store_at(input mips_isa_pkg::reg_addr_t rt,
      input int idx);
      return i_type(mips_isa_pkg::op_sw, rt, mips_isa_pkg::reg_zero,
                    mips_isa_pkg::imm16_t'(4 * idx));
   endfunction

   // expected R-type results from the instruction definitions
   function automatic mips_isa_pkg::word_t reference_result(input mips_isa_pkg::funct_t fn,
      input mips_isa_pkg::word_t a, input mips_isa_pkg::word_t b);
      case (fn)
         mips_isa_pkg::funct_subu: return a - b;
         mips_isa_pkg::funct_and:  return a & b;
         mips_isa_pkg::funct_or:   return a | b;
         mips_isa_pkg::funct_xor:  return a ^ b;
         mips_isa_pkg::funct_nor:  return ~(a | b);
         mips_isa_pkg::funct_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         mips_isa_pkg::funct_sltu: return (a < b) ? 32'd1 : 32'd0;
         default:                  return a + b;
      endcase
   endfunction

   task automatic place(input mips_isa_pkg::word_t word);
      imem[prog_len] = word;
      prog_len++;
   endtask

   // lui then ori
   task automatic set_register(input mips_isa_pkg::reg_addr_t rt,
      input mips_isa_pkg::word_t value);
      place(i_type(mips_isa_pkg::op_lui, rt, mips_isa_pkg::reg_zero, value[31:16]));
      place(i_type(mips_isa_pkg::op_ori, rt, rt, value[15:0]));
   endtask

   task automatic exit_syscall();
      place(i_type(mips_isa_pkg::op_addiu, mips_isa_pkg::reg_v0, mips_isa_pkg::reg_zero,
                   mips_isa_pkg::imm16_t'(mips_isa_pkg::syscall_exit)));
      place(r_type(mips_isa_pkg::funct_syscall, 5'd0, 5'd0, 5'd0));
   endtask

   // reset goes low and program space returns to no-ops
   task automatic begin_program();
      @(posedge clk);
      #1 rst_b = 1'b0;
      for (int i = 0; i < mem_words; i++)
         imem[i] = '0;
      prog_len = 0;
   endtask

   task automatic run_to_halt();
      int cycles;
      cycles = 0;
      repeat (8) @(posedge clk);
      #1 rst_b = 1'b1;
      while (!halted && cycles < run_limit) begin
         @(posedge clk);
         #1;
         cycles++;
      end
   endtask

   task automatic compare_word(input string name, input mips_isa_pkg::word_t expected,
      input mips_isa_pkg::word_t actual);
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic verify_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s expected %b actual %b", name, expected, actual);
      end
   endtask

   task automatic alu_ops();
      mips_isa_pkg::funct_t fns [8] = '{mips_isa_pkg::funct_addu, mips_isa_pkg::funct_subu,
         mips_isa_pkg::funct_and, mips_isa_pkg::funct_or, mips_isa_pkg::funct_xor,
         mips_isa_pkg::funct_nor, mips_isa_pkg::funct_slt, mips_isa_pkg::funct_sltu};
      mips_isa_pkg::word_t  a;
      mips_isa_pkg::word_t  b;
      mips_isa_pkg::imm16_t imm;
      a = $urandom();
      b = $urandom();
      imm = mips_isa_pkg::imm16_t'($urandom());
      begin_program();
      set_register(5'd8, a);
      set_register(5'd9, b);
      // each result is stored right behind the op that makes it
      for (int k = 0; k < 8; k++) begin
         place(r_type(fns[k], 5'd10, 5'd8, 5'd9));
         place(store_at(5'd10, k));
      end
      place(i_type(mips_isa_pkg::op_addiu, 5'd10, 5'd8, imm));
      place(store_at(5'd10, 8));
      place(i_type(mips_isa_pkg::op_ori, 5'd10, 5'd8, imm));
      place(store_at(5'd10, 9));
      exit_syscall();
      run_to_halt();
      verify_flag("alu halt", 1'b1, halted);
      for (int k = 0; k < 8; k++)
         compare_word($sformatf("alu %s", fns[k].name()), reference_result(fns[k], a, b),
                      dmem[k]);
      // addiu sign-extends while ori zero-extends
      compare_word("alu addiu", a + {{16{imm[15]}}, imm}, dmem[8]);
      compare_word("alu ori", a | {16'h0000, imm}, dmem[9]);
   endtask

   task automatic forwarding_chain();
      mips_isa_pkg::word_t     sums [8];
      mips_isa_pkg::reg_addr_t back;
      sums[0] = $urandom();
      begin_program();
      set_register(5'd8, sums[0]);
      // r(8+k) = r(7+k) + r(6+k) reads one and two instructions back
      for (int k = 1; k < 7; k++) begin
         back = (k == 1) ? 5'd8 : mips_isa_pkg::reg_addr_t'(6 + k);
         place(r_type(mips_isa_pkg::funct_addu, mips_isa_pkg::reg_addr_t'(8 + k),
                      mips_isa_pkg::reg_addr_t'(7 + k), back));
         sums[k] = sums[k - 1] + sums[(k == 1) ? 0 : k - 2];
      end
      // r12 is three back, so it comes through the register file bypass
      place(r_type(mips_isa_pkg::funct_addu, 5'd15, 5'd14, 5'd12));
      sums[7] = sums[6] + sums[4];
      for (int k = 1; k < 8; k++)
         place(store_at(mips_isa_pkg::reg_addr_t'(8 + k), k - 1));
      exit_syscall();
      run_to_halt();
      verify_flag("forward halt", 1'b1, halted);
      for (int k = 1; k < 8; k++)
         compare_word($sformatf("forward sum %0d", k), sums[k], dmem[k - 1]);
   endtask

   task automatic load_use();
      mips_isa_pkg::word_t  a;
      mips_isa_pkg::imm16_t imm;
      a = $urandom();
      imm = mips_isa_pkg::imm16_t'($urandom());
      begin_program();
      set_register(5'd8, a);
      place(i_type(mips_isa_pkg::op_addiu, 5'd11, mips_isa_pkg::reg_zero, imm));
      place(store_at(5'd8, 16));
      place(i_type(mips_isa_pkg::op_lw, 5'd9, mips_isa_pkg::reg_zero, 16'h0040));
      // reads the loaded register in the very next slot
      place(r_type(mips_isa_pkg::funct_addu, 5'd10, 5'd9, 5'd11));
      place(store_at(5'd10, 0));
      place(i_type(mips_isa_pkg::op_lw, 5'd12, mips_isa_pkg::reg_zero, 16'h0040));
      place(store_at(5'd12, 1));
      exit_syscall();
      run_to_halt();
      verify_flag("load-use halt", 1'b1, halted);
      compare_word("load-use sum", a + {{16{imm[15]}}, imm}, dmem[0]);
      compare_word("load-use store", a, dmem[1]);
   endtask

   task automatic branch_paths();
      mips_isa_pkg::word_t v;
      v = $urandom();
      begin_program();
      set_register(5'd8, v);
      place(r_type(mips_isa_pkg::funct_addu, 5'd9, 5'd8, 5'd0));
      // beq at index 3 is taken to 6
      place(i_type(mips_isa_pkg::op_beq, 5'd9, 5'd8, 16'd2));
      place(store_at(5'd8, 8));
      place(store_at(5'd8, 9));
      place(store_at(5'd9, 0));
      // bne at index 7 is not taken since r8 equals r9
      place(i_type(mips_isa_pkg::op_bne, 5'd9, 5'd8, 16'd2));
      place(store_at(5'd8, 1));
      place(jump_to(12));
      place(store_at(5'd8, 10));
      place(store_at(5'd8, 11));
      place(store_at(5'd9, 2));
      exit_syscall();
      run_to_halt();
      verify_flag("branch halt", 1'b1, halted);
      compare_word("beq target store", v, dmem[0]);
      compare_word("bne fall-through store", v, dmem[1]);
      compare_word("j target store", v, dmem[2]);
      for (int k = 8; k < 12; k++)
         compare_word($sformatf("wrong-path marker %0d", k), fill_value(k), dmem[k]);
   endtask

   task automatic halt_behavior();
      mips_isa_pkg::word_t v;
      v = $urandom();
      begin_program();
      place(i_type(mips_isa_pkg::op_addiu, mips_isa_pkg::reg_v0, mips_isa_pkg::reg_zero, 16'd5));
      place(r_type(mips_isa_pkg::funct_syscall, 5'd0, 5'd0, 5'd0));
      set_register(5'd8, v);
      place(store_at(5'd8, 0));
      exit_syscall();
      place(store_at(5'd8, 1));
      place(store_at(5'd8, 2));
      run_to_halt();
      // give any late store time to land
      repeat (4) @(posedge clk);
      #1;
      verify_flag("exit syscall halt", 1'b1, halted);
      compare_word("store after other syscall", v, dmem[0]);
      compare_word("store after halt 1", fill_value(1), dmem[1]);
      compare_word("store after halt 2", fill_value(2), dmem[2]);
   endtask

   initial begin
      #(test_count * cycles_per_test * clk_period);
      $display("watchdog expired before the tests finished");
      $display("Some tests failed");
      $finish;
   end

   initial begin
      rst_b = 1'b0;
      errors = 0;
      prog_len = 0;
      for (int i = 0; i < mem_words; i++)
         imem[i] = '0;
      void'($urandom(32'hf8e8e19f));
      alu_ops();
      forwarding_chain();
      load_use();
      branch_paths();
      halt_behavior();
      $display("failed checks %0d, failed assertions %0d", errors,
               UUT.u_properties.fail_count);
      if (errors == 0 && UUT.u_properties.fail_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- bench/mips_core_properties.sv
// concurrent checks on the core's store strobe, halt, fetch address and hazard signals
`timescale 1ns/1ps

module mips_core_properties (
   input logic                     clk,
   input logic                     rst_b,
   input mips_isa_pkg::word_addr_t inst_addr,
   input logic [3:0]               mem_write_en,
   input logic                     halted,
   input logic                     stall,
   input logic                     flush
);

   // number of failed assertions so far
   int fail_count = 0;

   // only whole-word stores exist
   strobe_whole_word: assert property (@(posedge clk) disable iff (!rst_b)
      mem_write_en == 4'h0 || mem_write_en == 4'hf)
      else begin
         fail_count++;
         $error("mem_write_en is neither zero nor all ones");
      end

   // halt is sticky until the next reset
   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b) halted |=> halted)
      else begin
         fail_count++;
         $error("halted dropped without a reset");
      end

   // a halted core fetches nothing new
   fetch_frozen: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else begin
         fail_count++;
         $error("inst_addr moved while the core was halted");
      end

   // a load in EX and a taken branch in EX cannot coexist
   no_stall_and_flush: assert property (@(posedge clk) disable iff (!rst_b) !(stall && flush))
      else begin
         fail_count++;
         $error("stall and flush were high in the same cycle");
      end

endmodule

//--- source/mips_core.sv
// five-stage pipeline top with PC, stage registers, memory stage, writeback and halt
`timescale 1ns/1ps

module mips_core (
   input  logic                     clk,
   input  logic                     rst_b,
   output mips_isa_pkg::word_addr_t inst_addr,
   input  mips_isa_pkg::word_t      inst,
   output mips_isa_pkg::word_addr_t mem_addr,
   output mips_isa_pkg::word_t      mem_data_in,
   output logic [3:0]               mem_write_en,
   input  mips_isa_pkg::word_t      mem_data_out,
   output logic                     halted
);

   mips_isa_pkg::word_t     pc;
   // IF/ID register, an all-zero word decodes as a no-op
   mips_isa_pkg::word_t     if_id_pc;
   mips_isa_pkg::word_t     if_id_inst;

   mips_pipe_pkg::id_ex_t   id_ex;
   mips_pipe_pkg::fwd_sel_t fwd_rs_ex;
   mips_pipe_pkg::fwd_sel_t fwd_rt_ex;
   mips_pipe_pkg::ex_mem_t  ex_mem;
   mips_pipe_pkg::mem_wb_t  mem_wb;

   // decode outputs
   mips_pipe_pkg::ctrl_t    id_ctrl;
   mips_isa_pkg::reg_addr_t id_rs;
   mips_isa_pkg::reg_addr_t id_rt;
   mips_isa_pkg::reg_addr_t id_dest;
   mips_isa_pkg::word_t     id_imm;
   mips_isa_pkg::word_t     id_jump_target;
   mips_isa_pkg::word_t     id_rs_data;
   mips_isa_pkg::word_t     id_rt_data;

   // hazard and execute outputs
   logic                    stall;
   logic                    flush;
   mips_pipe_pkg::fwd_sel_t fwd_rs;
   mips_pipe_pkg::fwd_sel_t fwd_rt;
   mips_isa_pkg::word_t     alu_result;
   mips_isa_pkg::word_t     store_data;
   logic                    branch_taken;
   mips_isa_pkg::word_t     branch_target;

   mips_isa_pkg::word_t     mem_wb_data;
   logic                    halt_next;
   logic                    run;

   mips_decode u_decode (
      .inst        (if_id_inst),
      .pc          (if_id_pc),
      .ctrl        (id_ctrl),
      .rs          (id_rs),
      .rt_read     (id_rt),
      .dest        (id_dest),
      .imm         (id_imm),
      .jump_target (id_jump_target)
   );

   // written from WB, frozen once halted
   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs      (id_rs),
      .rt      (id_rt),
      .wr_en   (mem_wb.reg_we & run),
      .wr_addr (mem_wb.dest),
      .wr_data (mem_wb.wb_data),
      .rs_data (id_rs_data),
      .rt_data (id_rt_data)
   );

   mips_hazard u_hazard (
      .id_rs        (id_rs),
      .id_rt        (id_rt),
      .id_ex        (id_ex),
      .ex_mem       (ex_mem),
      .branch_taken (branch_taken),
      .stall        (stall),
      .flush        (flush),
      .fwd_rs       (fwd_rs),
      .fwd_rt       (fwd_rt)
   );

   mips_execute u_execute (
      .id_ex         (id_ex),
      .fwd_rs        (fwd_rs_ex),
      .fwd_rt        (fwd_rt_ex),
      .mem_result    (ex_mem.alu_result),
      .wb_data       (mem_wb.wb_data),
      .alu_result    (alu_result),
      .store_data    (store_data),
      .branch_taken  (branch_taken),
      .branch_target (branch_target)
   );

   // halting syscall sits in WB now, so the store behind it must not land
   assign halt_next = halted | (mem_wb.syscall & (mem_wb.rt_data == mips_isa_pkg::syscall_exit));
   assign run       = ~halted;

   assign inst_addr    = pc[31:2];
   assign mem_addr     = ex_mem.alu_result[31:2];
   assign mem_data_in  = ex_mem.store_data;
   assign mem_write_en = {4{ex_mem.ctrl.mem_write & ~halt_next}};

   // memory answers in the same cycle
   assign mem_wb_data = ex_mem.ctrl.mem_read ? mem_data_out : ex_mem.alu_result;

   // fetch side, a redirect from EX beats the load-use hold
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc         <= mips_isa_pkg::text_start;
         if_id_pc   <= '0;
         if_id_inst <= '0;
      end else if (run) begin
         if (branch_taken)
            pc <= branch_target;
         else if (!stall)
            pc <= pc + 32'd4;
         if (flush) begin
            if_id_inst <= '0;
         end else if (!stall) begin
            if_id_pc   <= pc;
            if_id_inst <= inst;
         end
      end
   end

   // EX entry, bubble on flush or when the load-use hold keeps ID in place
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         id_ex     <= '0;
         fwd_rs_ex <= mips_pipe_pkg::from_reg;
         fwd_rt_ex <= mips_pipe_pkg::from_reg;
      end else if (run) begin
         fwd_rs_ex <= fwd_rs;
         fwd_rt_ex <= fwd_rt;
         if (flush || stall) begin
            id_ex.ctrl <= '0;
         end else begin
            id_ex.ctrl    <= id_ctrl;
            id_ex.pc      <= if_id_pc;
            id_ex.rs_data <= id_rs_data;
            id_ex.rt_data <= id_rt_data;
            id_ex.imm     <= id_ctrl.jump ? id_jump_target : id_imm;
            id_ex.rs      <= id_rs;
            id_ex.rt      <= id_rt;
            id_ex.dest    <= id_dest;
         end
      end
   end

   // MEM and WB entries always advance until halt
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_mem <= '0;
         mem_wb <= '0;
      end else if (run) begin
         ex_mem.ctrl       <= id_ex.ctrl;
         ex_mem.alu_result <= alu_result;
         ex_mem.store_data <= store_data;
         ex_mem.dest       <= id_ex.dest;
         mem_wb.reg_we     <= ex_mem.ctrl.reg_we;
         mem_wb.syscall    <= ex_mem.ctrl.syscall;
         mem_wb.wb_data    <= mem_wb_data;
         mem_wb.dest       <= ex_mem.dest;
         mem_wb.rt_data    <= ex_mem.store_data;
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b)
         halted <= 1'b0;
      else
         halted <= halt_next;
   end

endmodule

//--- source/mips_execute.sv
// EX stage with operand forwarding, ALU, branch compare and target
`timescale 1ns/1ps

module mips_execute (
   input  mips_pipe_pkg::id_ex_t   id_ex,
   input  mips_pipe_pkg::fwd_sel_t fwd_rs,
   input  mips_pipe_pkg::fwd_sel_t fwd_rt,
   input  mips_isa_pkg::word_t     mem_result,
   input  mips_isa_pkg::word_t     wb_data,
   output mips_isa_pkg::word_t     alu_result,
   output mips_isa_pkg::word_t     store_data,
   output logic                    branch_taken,
   output mips_isa_pkg::word_t     branch_target
);

   mips_isa_pkg::word_t rs_val;
   mips_isa_pkg::word_t rt_val;
   mips_isa_pkg::word_t op_b;

   function automatic mips_isa_pkg::word_t fwd_mux(
      input mips_pipe_pkg::fwd_sel_t sel,
      input mips_isa_pkg::word_t     reg_val
   );
      mips_isa_pkg::word_t val;
      case (sel)
         mips_pipe_pkg::from_mem: val = mem_result;
         mips_pipe_pkg::from_wb:  val = wb_data;
         default:                 val = reg_val;
      endcase
      return val;
   endfunction

   assign rs_val = fwd_mux(fwd_rs, id_ex.rs_data);
   assign rt_val = fwd_mux(fwd_rt, id_ex.rt_data);
   assign op_b   = id_ex.ctrl.use_imm ? id_ex.imm : rt_val;

   // SW data and the syscall's $v0 both leave through here
   assign store_data = rt_val;

   always_comb begin
      case (id_ex.ctrl.alu_op)
         mips_pipe_pkg::alu_add:  alu_result = rs_val + op_b;
         mips_pipe_pkg::alu_sub:  alu_result = rs_val - op_b;
         mips_pipe_pkg::alu_and:  alu_result = rs_val & op_b;
         mips_pipe_pkg::alu_or:   alu_result = rs_val | op_b;
         mips_pipe_pkg::alu_xor:  alu_result = rs_val ^ op_b;
         mips_pipe_pkg::alu_nor:  alu_result = ~(rs_val | op_b);
         mips_pipe_pkg::alu_slt:  alu_result = {31'b0, $signed(rs_val) < $signed(op_b)};
         mips_pipe_pkg::alu_sltu: alu_result = {31'b0, rs_val < op_b};
         mips_pipe_pkg::alu_lui:  alu_result = {op_b[15:0], 16'h0000};
         default:                 alu_result = rs_val + op_b;
      endcase
   end

   // compare uses forwarded operands, not the immediate
   assign branch_taken = id_ex.ctrl.jump
                       | (id_ex.ctrl.branch_eq & (rs_val == rt_val))
                       | (id_ex.ctrl.branch_ne & (rs_val != rt_val));

   // for J the decoder already put the absolute target in imm
   assign branch_target = id_ex.ctrl.jump ? id_ex.imm
                        : id_ex.pc + 32'd4 + {id_ex.imm[29:0], 2'b00};

endmodule

//--- source/mips_hazard.sv
// forward selection for ID sources, load-use stall and taken-branch flush
`timescale 1ns/1ps

module mips_hazard (
   input  mips_isa_pkg::reg_addr_t id_rs,
   input  mips_isa_pkg::reg_addr_t id_rt,
   input  mips_pipe_pkg::id_ex_t   id_ex,
   input  mips_pipe_pkg::ex_mem_t  ex_mem,
   input  logic                    branch_taken,
   output logic                    stall,
   output logic                    flush,
   output mips_pipe_pkg::fwd_sel_t fwd_rs,
   output mips_pipe_pkg::fwd_sel_t fwd_rt
);

   logic load_in_ex;

   // chosen one cycle early, so the instruction now in EX will be in MEM
   // and the one now in MEM will be in WB when the ID source reaches EX
   function automatic mips_pipe_pkg::fwd_sel_t select_fwd(
      input mips_isa_pkg::reg_addr_t src
   );
      mips_pipe_pkg::fwd_sel_t sel;
      sel = mips_pipe_pkg::from_reg;
      if (src != mips_isa_pkg::reg_zero) begin
         // younger producer wins
         if (id_ex.ctrl.reg_we && id_ex.dest == src)
            sel = mips_pipe_pkg::from_mem;
         else if (ex_mem.ctrl.reg_we && ex_mem.dest == src)
            sel = mips_pipe_pkg::from_wb;
      end
      return sel;
   endfunction

   assign fwd_rs = select_fwd(id_rs);
   assign fwd_rt = select_fwd(id_rt);

   // load data only exists in MEM, one cycle too late for the next instruction
   assign load_in_ex = id_ex.ctrl.mem_read && id_ex.dest != mips_isa_pkg::reg_zero;
   assign stall = load_in_ex && (id_ex.dest == id_rs || id_ex.dest == id_rt);

   // branch_taken already covers J, both younger instructions are dropped
   assign flush = branch_taken;

endmodule

//--- source/mips_regfile.sv
// 32-entry register file, two read ports, one write port, same-cycle write bypass
`timescale 1ns/1ps

module mips_regfile (
   input  logic                    clk,
   input  logic                    rst_b,
   input  mips_isa_pkg::reg_addr_t rs,
   input  mips_isa_pkg::reg_addr_t rt,
   input  logic                    wr_en,
   input  mips_isa_pkg::reg_addr_t wr_addr,
   input  mips_isa_pkg::word_t     wr_data,
   output mips_isa_pkg::word_t     rs_data,
   output mips_isa_pkg::word_t     rt_data
);

   // entry 0 is not stored
   mips_isa_pkg::word_t regs [31:1];

   // $zero, then the value being written back, then storage
   function automatic mips_isa_pkg::word_t read_port(input mips_isa_pkg::reg_addr_t addr);
      mips_isa_pkg::word_t data;
      if (addr == mips_isa_pkg::reg_zero)
         data = '0;
      else if (wr_en && wr_addr == addr)
         data = wr_data;
      else
         data = regs[addr];
      return data;
   endfunction

   assign rs_data = read_port(rs);
   assign rt_data = read_port(rt);

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end else if (wr_en && wr_addr != mips_isa_pkg::reg_zero) begin
         regs[wr_addr] <= wr_data;
      end
   end

endmodule

//--- source/mips_decode.sv
// ID-stage decoder producing control, register numbers, immediate and jump target
`timescale 1ns/1ps

module mips_decode (
   input  mips_isa_pkg::word_t     inst,
   input  mips_isa_pkg::word_t     pc,
   output mips_pipe_pkg::ctrl_t    ctrl,
   output mips_isa_pkg::reg_addr_t rs,
   output mips_isa_pkg::reg_addr_t rt_read,
   output mips_isa_pkg::reg_addr_t dest,
   output mips_isa_pkg::word_t     imm,
   output mips_isa_pkg::word_t     jump_target
);

   mips_isa_pkg::opcode_t opcode;
   mips_isa_pkg::funct_t  funct;
   mips_isa_pkg::imm16_t  imm_field;

   assign opcode    = mips_isa_pkg::opcode_t'(inst[31:26]);
   assign funct     = mips_isa_pkg::funct_t'(inst[5:0]);
   assign imm_field = inst[15:0];
   assign rs        = inst[25:21];

   always_comb begin
      // anything not matched below stays a no-op
      ctrl = '0;
      case (opcode)
         mips_isa_pkg::op_special: begin
            ctrl.reg_we = 1'b1;
            case (funct)
               mips_isa_pkg::funct_addu: ctrl.alu_op = mips_pipe_pkg::alu_add;
               mips_isa_pkg::funct_subu: ctrl.alu_op = mips_pipe_pkg::alu_sub;
               mips_isa_pkg::funct_and:  ctrl.alu_op = mips_pipe_pkg::alu_and;
               mips_isa_pkg::funct_or:   ctrl.alu_op = mips_pipe_pkg::alu_or;
               mips_isa_pkg::funct_xor:  ctrl.alu_op = mips_pipe_pkg::alu_xor;
               mips_isa_pkg::funct_nor:  ctrl.alu_op = mips_pipe_pkg::alu_nor;
               mips_isa_pkg::funct_slt:  ctrl.alu_op = mips_pipe_pkg::alu_slt;
               mips_isa_pkg::funct_sltu: ctrl.alu_op = mips_pipe_pkg::alu_sltu;
               mips_isa_pkg::funct_syscall: begin
                  ctrl.reg_we  = 1'b0;
                  ctrl.syscall = 1'b1;
               end
               // unknown function code
               default: ctrl.reg_we = 1'b0;
            endcase
         end
         mips_isa_pkg::op_addiu: begin
            ctrl.reg_we  = 1'b1;
            ctrl.use_imm = 1'b1;
         end
         mips_isa_pkg::op_ori: begin
            ctrl.reg_we   = 1'b1;
            ctrl.alu_op   = mips_pipe_pkg::alu_or;
            ctrl.use_imm  = 1'b1;
            ctrl.zero_ext = 1'b1;
         end
         mips_isa_pkg::op_lui: begin
            ctrl.reg_we  = 1'b1;
            ctrl.alu_op  = mips_pipe_pkg::alu_lui;
            ctrl.use_imm = 1'b1;
         end
         mips_isa_pkg::op_lw: begin
            // address is rs plus the sign-extended offset
            ctrl.reg_we   = 1'b1;
            ctrl.use_imm  = 1'b1;
            ctrl.mem_read = 1'b1;
         end
         mips_isa_pkg::op_sw: begin
            ctrl.use_imm   = 1'b1;
            ctrl.mem_write = 1'b1;
         end
         mips_isa_pkg::op_beq: ctrl.branch_eq = 1'b1;
         mips_isa_pkg::op_bne: ctrl.branch_ne = 1'b1;
         mips_isa_pkg::op_j:   ctrl.jump      = 1'b1;
         default: ctrl = '0;
      endcase
   end

   // syscall reads $v0 through the rt port so it gets forwarded like any operand
   assign rt_read = ctrl.syscall ? mips_isa_pkg::reg_v0 : inst[20:16];

   // rd for R-type, rt for immediates and loads
   assign dest = (opcode == mips_isa_pkg::op_special) ? inst[15:11] : inst[20:16];

   assign imm = ctrl.zero_ext ? {16'h0000, imm_field} : {{16{imm_field[15]}}, imm_field};

   // region bits come from the jump's own pc
   assign jump_target = {pc[31:28], inst[25:0], 2'b00};

endmodule

//--- source/mips_pipe_pkg.sv
// ALU and forward-select enums, control struct and pipeline stage-register structs
package mips_pipe_pkg;

   // operations the EX-stage ALU can run
   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_nor,
      alu_slt,
      alu_sltu,
      // places the immediate in the upper half
      alu_lui
   } alu_op_t;

   // where an EX operand comes from
   typedef enum logic [1:0] {
      from_reg,
      from_mem,
      from_wb
   } fwd_sel_t;

   // decoded control, all zero is a bubble
   typedef struct packed {
      logic    reg_we;
      alu_op_t alu_op;
      // second ALU operand is the immediate
      logic    use_imm;
      // zero-extend instead of sign-extend
      logic    zero_ext;
      logic    mem_read;
      logic    mem_write;
      logic    branch_eq;
      logic    branch_ne;
      logic    jump;
      logic    syscall;
   } ctrl_t;

   // ID/EX register, imm holds the jump target for J
   typedef struct packed {
      ctrl_t                 ctrl;
      mips_isa_pkg::word_t     pc;
      mips_isa_pkg::word_t     rs_data;
      mips_isa_pkg::word_t     rt_data;
      mips_isa_pkg::word_t     imm;
      mips_isa_pkg::reg_addr_t rs;
      mips_isa_pkg::reg_addr_t rt;
      mips_isa_pkg::reg_addr_t dest;
   } id_ex_t;

   // EX/MEM register
   typedef struct packed {
      ctrl_t                 ctrl;
      mips_isa_pkg::word_t     alu_result;
      mips_isa_pkg::word_t     store_data;
      mips_isa_pkg::reg_addr_t dest;
   } ex_mem_t;

   // MEM/WB register, rt_data is $v0 for a syscall
   typedef struct packed {
      logic                  reg_we;
      logic                  syscall;
      mips_isa_pkg::word_t     wb_data;
      mips_isa_pkg::reg_addr_t dest;
      mips_isa_pkg::word_t     rt_data;
   } mem_wb_t;

endpackage

//--- source/mips_isa_pkg.sv
// instruction-set types, opcode and function-code enums, register numbers and syscall code
package mips_isa_pkg;

   // data word, byte address or raw instruction
   typedef logic [31:0] word_t;
   // architectural register number
   typedef logic [4:0] reg_addr_t;
   // raw immediate field of an I-type instruction
   typedef logic [15:0] imm16_t;
   // word address as driven on the memory ports
   typedef logic [29:0] word_addr_t;

   // primary opcodes, bits 31:26
   typedef enum logic [5:0] {
      op_special = 6'h00,
      op_j       = 6'h02,
      op_beq     = 6'h04,
      op_bne     = 6'h05,
      op_addiu   = 6'h09,
      op_ori     = 6'h0d,
      op_lui     = 6'h0f,
      op_lw      = 6'h23,
      op_sw      = 6'h2b
   } opcode_t;

   // function codes of SPECIAL, bits 5:0
   typedef enum logic [5:0] {
      funct_syscall = 6'h0c,
      funct_addu    = 6'h21,
      funct_subu    = 6'h23,
      funct_and     = 6'h24,
      funct_or      = 6'h25,
      funct_xor     = 6'h26,
      funct_nor     = 6'h27,
      funct_slt     = 6'h2a,
      funct_sltu    = 6'h2b
   } funct_t;

   // first instruction fetched after reset
   localparam word_t text_start = 32'h0040_0000;

   // $zero reads as 0 and is never written
   localparam reg_addr_t reg_zero = 5'd0;
   // $v0 carries the syscall code
   localparam reg_addr_t reg_v0 = 5'd2;

   // $v0 value that makes SYSCALL stop the core
   localparam word_t syscall_exit = 32'd10;

endpackage
